//--- src/tilemap_defines.svh
`ifndef TILEMAP_DEFINES_SVH
`define TILEMAP_DEFINES_SVH

// Pattern word and pixel field widths
`define TM_PATTERN_W 12
`define TM_PLANE_W 4
`define TM_PRIO_W 3
`define TM_COLOUR_W 8
`define TM_DOT_W 3

// Line timing
`define TM_GROUPS 8
`define TM_LINE_LEN 48
`define TM_HCOUNT_W 6
`define TM_INDEX_W 3
`define TM_ACTIVE_START 4

// Register file on the shared bus
`define TM_ADDR_W 3
`define TM_REG_PRIO_A 1
`define TM_REG_PRIO_B 5

`endif

//--- src/tilemapPkg.sv
`include "tilemap_defines.svh"

package tilemapPkg;

	////////////////////
	// Shared data bus
	////////////////////

	// Register view of the bus
	// Priority sits in bits 3 to 1
	typedef struct packed {
		logic [`TM_COLOUR_W-`TM_PRIO_W-2:0] spareHi;
		logic [`TM_PRIO_W-1:0] prio;
		logic spareLo;
	} mdiReg_s;

	// Same wire seen as a tile attribute or as a register write
	typedef union packed {
		logic [`TM_COLOUR_W-1:0] colour;
		mdiReg_s regs;
	} mdiWord_u;

endpackage

//--- src/tileFetcher.sv
`include "tilemap_defines.svh"

module tileFetcher (
	input  logic CLK_6M,
	input  logic rstN,
	// Row memory load port
	input  logic ramWe,
	input  logic ramLayer,
	input  logic [`TM_INDEX_W-1:0] ramIndex,
	input  logic [`TM_PATTERN_W-1:0] ramPattern,
	input  logic [`TM_COLOUR_W-1:0] ramAttr,
	// Priority register write request
	input  logic cpuWe,
	input  logic [`TM_ADDR_W-1:0] cpuAddr,
	input  tilemapPkg::mdiWord_u cpuData,
	output logic cpuReady,
	// Shared bus towards the shifter
	output logic [`TM_PATTERN_W-1:0] gdi,
	output tilemapPkg::mdiWord_u mdi,
	output logic loadA,
	output logic loadB,
	output logic latch,
	output logic [`TM_ADDR_W-1:0] ca,
	output logic active
);

	localparam int HW = `TM_HCOUNT_W;
	// Last cycle of the line
	localparam logic [HW-1:0] lineLast = HW'(`TM_LINE_LEN - 1);
	// Loads cover all groups, four cycles each
	localparam logic [HW-1:0] loadEnd = HW'(`TM_GROUPS * `TM_PLANE_W);
	// Pixels trail the loads by one group slot
	localparam logic [HW-1:0] actStart = HW'(`TM_ACTIVE_START);
	localparam logic [HW-1:0] actEnd = HW'(`TM_ACTIVE_START + `TM_GROUPS * `TM_PLANE_W);

	logic [HW-1:0] hCount;
	logic [1:0] phase;
	logic [`TM_INDEX_W-1:0] group;
	logic loadWindow;
	logic cpuSlot;

	// Row memories, index 0 is layer A and index 1 is layer B
	logic [`TM_PATTERN_W-1:0] patMem [2][`TM_GROUPS];
	logic [`TM_COLOUR_W-1:0] attrMem [2][`TM_GROUPS];

	////////////////////
	// Line counter
	////////////////////

	always_ff @(posedge CLK_6M) begin
		if (!rstN) begin
			hCount <= '0;
		end else if (hCount == lineLast) begin
			hCount <= '0;
		end else begin
			hCount <= hCount + 1'b1;
		end
	end

	// Row memory write, no handshake
	always_ff @(posedge CLK_6M) begin
		if (ramWe) begin
			patMem[ramLayer][ramIndex] <= ramPattern;
			attrMem[ramLayer][ramIndex] <= ramAttr;
		end
	end

	////////////////////
	// Strobes and grant
	////////////////////

	always_comb begin
		phase = hCount[1:0];
		group = hCount[2 +: `TM_INDEX_W];
		loadWindow = hCount < loadEnd;
		// Phases 0 and 1 belong to the processor
		cpuSlot = !phase[1];
		cpuReady = cpuWe && cpuSlot;
		// Write completes on the edge ending this cycle
		latch = cpuReady;
		ca = cpuAddr;
		// Phase 2 carries layer A, phase 3 layer B
		loadA = loadWindow && (phase == 2'd2);
		loadB = loadWindow && (phase == 2'd3);
		active = (hCount >= actStart) && (hCount < actEnd);
	end

	// Bus mux
	always_comb begin
		if (cpuSlot) begin
			gdi = '0;
			mdi = cpuData;
		end else begin
			// Low phase bit picks the layer
			gdi = patMem[phase[0]][group];
			mdi.colour = attrMem[phase[0]][group];
		end
	end

endmodule

//--- src/tileShifter.sv
`include "tilemap_defines.svh"

module tileShifter (
	input  logic CLK_6M,
	input  logic rstN,
	// Shared bus from the fetcher
	input  logic [`TM_PATTERN_W-1:0] gdi,
	input  tilemapPkg::mdiWord_u mdi,
	input  logic loadA,
	input  logic loadB,
	input  logic latch,
	input  logic [`TM_ADDR_W-1:0] ca,
	input  logic flip,
	// Upstream layer
	input  logic [`TM_PRIO_W-1:0] priIn,
	input  logic [`TM_COLOUR_W-1:0] colourIn,
	input  logic [`TM_DOT_W-1:0] dotIn,
	// Winning pixel
	output logic [`TM_PRIO_W-1:0] priSel,
	output logic [`TM_COLOUR_W-1:0] colourSel,
	output logic [`TM_DOT_W-1:0] dotSel
);

	localparam int PW = `TM_PLANE_W;
	// One bit plane per dot bit
	localparam int NP = `TM_DOT_W;

	// Plane shift registers, head is the top bit
	logic [NP-1:0][PW-1:0] planeA;
	logic [NP-1:0][PW-1:0] planeB;
	logic [`TM_COLOUR_W-1:0] colourA;
	logic [`TM_COLOUR_W-1:0] colourB;
	logic [`TM_PRIO_W-1:0] prioA;
	logic [`TM_PRIO_W-1:0] prioB;

	// Layer A is held here until layer B arrives
	logic [`TM_PATTERN_W-1:0] holdPattern;
	logic [`TM_COLOUR_W-1:0] holdColour;

	logic [`TM_DOT_W-1:0] dotA;
	logic [`TM_DOT_W-1:0] dotB;
	logic [`TM_PRIO_W-1:0] midPri;
	logic [`TM_COLOUR_W-1:0] midColour;
	logic [`TM_DOT_W-1:0] midDot;

	// Reverse a plane so pixel 0 leaves first under flip
	function automatic logic [PW-1:0] orderPlane(input logic [PW-1:0] plane, input logic rev);
		logic [PW-1:0] flipped;
		for (int i = 0; i < PW; i++) begin
			flipped[i] = plane[PW-1-i];
		end
		return rev ? flipped : plane;
	endfunction

	////////////////////
	// Plane shifters
	////////////////////

	always_ff @(posedge CLK_6M) begin
		if (!rstN) begin
			planeA <= '0;
			planeB <= '0;
		end else if (loadB) begin
			// Both layers start the group together
			for (int i = 0; i < NP; i++) begin
				planeA[i] <= orderPlane(holdPattern[i*PW +: PW], flip);
				planeB[i] <= orderPlane(gdi[i*PW +: PW], flip);
			end
		end else begin
			// Free running shift, zeros fill in
			for (int i = 0; i < NP; i++) begin
				planeA[i] <= {planeA[i][PW-2:0], 1'b0};
				planeB[i] <= {planeB[i][PW-2:0], 1'b0};
			end
		end
	end

	// Holding latch and tile colours
	always_ff @(posedge CLK_6M) begin
		if (loadA) begin
			holdPattern <= gdi;
			holdColour <= mdi.colour;
		end
		if (loadB) begin
			colourA <= holdColour;
			colourB <= mdi.colour;
		end
	end

	////////////////////
	// Priority registers
	////////////////////

	// Decoded from the register view of the bus
	always_ff @(posedge CLK_6M) begin
		if (!rstN) begin
			prioA <= '0;
			prioB <= '0;
		end else if (latch) begin
			if (ca == `TM_ADDR_W'(`TM_REG_PRIO_A)) begin
				prioA <= mdi.regs.prio;
			end else if (ca == `TM_ADDR_W'(`TM_REG_PRIO_B)) begin
				prioB <= mdi.regs.prio;
			end
		end
	end

	////////////////////
	// Priority select
	////////////////////

	always_comb begin
		// Dot comes from the head of each plane
		for (int i = 0; i < NP; i++) begin
			dotA[i] = planeA[i][PW-1];
			dotB[i] = planeB[i][PW-1];
		end
		// B over A only with a visible dot and a higher priority
		if ((dotB != '0) && (prioB > prioA)) begin
			midPri = prioB;
			midColour = colourB;
			midDot = dotB;
		end else begin
			midPri = prioA;
			midColour = colourA;
			midDot = dotA;
		end
		// Same rule against the upstream layer
		if ((midDot != '0) && (midPri > priIn)) begin
			priSel = midPri;
			colourSel = midColour;
			dotSel = midDot;
		end else begin
			priSel = priIn;
			colourSel = colourIn;
			dotSel = dotIn;
		end
	end

endmodule

//--- src/pixelOutput.sv
`include "tilemap_defines.svh"

module pixelOutput (
	input  logic CLK_6M,
	input  logic rstN,
	input  logic active,
	input  logic [`TM_PRIO_W-1:0] priSel,
	input  logic [`TM_COLOUR_W-1:0] colourSel,
	input  logic [`TM_DOT_W-1:0] dotSel,
	output logic pixelValid,
	// Colour in the top bits, dot below
	output logic [`TM_COLOUR_W+`TM_DOT_W-1:0] palIndex,
	output logic [`TM_PRIO_W-1:0] pixelPri,
	output logic transparent
);

	////////////////////
	// Output register
	////////////////////

	// Valid follows the active window
	always_ff @(posedge CLK_6M) begin
		if (!rstN) begin
			pixelValid <= 1'b0;
		end else begin
			pixelValid <= active;
		end
	end

	always_ff @(posedge CLK_6M) begin
		if (active) begin
			palIndex <= {colourSel, dotSel};
			pixelPri <= priSel;
			// Dot 0 is see-through
			transparent <= (dotSel == '0);
		end else begin
			// Blanking forces index 0
			palIndex <= '0;
			pixelPri <= '0;
			transparent <= 1'b1;
		end
	end

endmodule

//--- src/tilemapTop.sv
`include "tilemap_defines.svh"

module tilemapTop (
	input  logic CLK_6M,
	input  logic rstN,
	// Row memory load
	input  logic ramWe,
	input  logic ramLayer,
	input  logic [`TM_INDEX_W-1:0] ramIndex,
	input  logic [`TM_PATTERN_W-1:0] ramPattern,
	input  logic [`TM_COLOUR_W-1:0] ramAttr,
	// Priority writes
	input  logic cpuWe,
	input  logic [`TM_ADDR_W-1:0] cpuAddr,
	input  tilemapPkg::mdiWord_u cpuData,
	output logic cpuReady,
	input  logic flip,
	// Upstream layer
	input  logic [`TM_PRIO_W-1:0] priIn,
	input  logic [`TM_COLOUR_W-1:0] colourIn,
	input  logic [`TM_DOT_W-1:0] dotIn,
	// Pixel stream
	output logic pixelValid,
	output logic [`TM_COLOUR_W+`TM_DOT_W-1:0] palIndex,
	output logic [`TM_PRIO_W-1:0] pixelPri,
	output logic transparent
);

	import tilemapPkg::*;

	// Shared bus between fetcher and shifter
	logic [`TM_PATTERN_W-1:0] gdi;
	mdiWord_u mdi;
	logic loadA;
	logic loadB;
	logic latch;
	logic [`TM_ADDR_W-1:0] ca;
	logic active;

	// Selected pixel
	logic [`TM_PRIO_W-1:0] priSel;
	logic [`TM_COLOUR_W-1:0] colourSel;
	logic [`TM_DOT_W-1:0] dotSel;

	////////////////////
	// Fetch stage
	////////////////////

	tileFetcher u_tileFetcher (
		.CLK_6M(CLK_6M), .rstN(rstN),
		.ramWe(ramWe), .ramLayer(ramLayer), .ramIndex(ramIndex),
		.ramPattern(ramPattern), .ramAttr(ramAttr),
		.cpuWe(cpuWe), .cpuAddr(cpuAddr), .cpuData(cpuData), .cpuReady(cpuReady),
		.gdi(gdi), .mdi(mdi), .loadA(loadA), .loadB(loadB),
		.latch(latch), .ca(ca), .active(active)
	);

	// Shifters and priority mux
	tileShifter u_tileShifter (
		.CLK_6M(CLK_6M), .rstN(rstN),
		.gdi(gdi), .mdi(mdi), .loadA(loadA), .loadB(loadB),
		.latch(latch), .ca(ca), .flip(flip),
		.priIn(priIn), .colourIn(colourIn), .dotIn(dotIn),
		.priSel(priSel), .colourSel(colourSel), .dotSel(dotSel)
	);

	// Blank and register
	pixelOutput u_pixelOutput (
		.CLK_6M(CLK_6M), .rstN(rstN), .active(active),
		.priSel(priSel), .colourSel(colourSel), .dotSel(dotSel),
		.pixelValid(pixelValid), .palIndex(palIndex),
		.pixelPri(pixelPri), .transparent(transparent)
	);

endmodule

//--- dv/tilemap_properties.sv
module tilemapProperties (
	input logic CLK_6M,
	input logic rstN,
	input logic loadA,
	input logic loadB,
	input logic latch,
	input logic cpuWe,
	input logic cpuReady
);

	////////////////////
	// Strobe ordering
	////////////////////

	// Layer B always follows layer A on the next cycle
	assert property (@(posedge CLK_6M) disable iff (!rstN) loadA |=> loadB)
		else $error("loadB did not follow loadA");

	// Register writes and pattern loads share the bus
	assert property (@(posedge CLK_6M) disable iff (!rstN) latch |-> !(loadA || loadB))
		else $error("latch overlaps a load strobe");

	////////////////////
	// Write handshake
	////////////////////

	// Ready only answers a request
	assert property (@(posedge CLK_6M) disable iff (!rstN) cpuReady |-> cpuWe)
		else $error("cpuReady high without cpuWe");

endmodule

bind tileFetcher tilemapProperties u_tilemapProperties (
	.CLK_6M(CLK_6M), .rstN(rstN), .loadA(loadA), .loadB(loadB),
	.latch(latch), .cpuWe(cpuWe), .cpuReady(cpuReady)
);

//--- dv/tilemapTb.sv
`include "tilemap_defines.svh"

module tilemapTb;

	import tilemapPkg::*;

	localparam int NPIX = `TM_GROUPS * `TM_PLANE_W;
	localparam int IDX_W = `TM_COLOUR_W + `TM_DOT_W;
	// Five tests at six lines each plus setup margin
	localparam int CYCLE_LIMIT = 5 * 6 * `TM_LINE_LEN + 200;

	logic CLK_6M;
	logic rstN;
	logic ramWe;
	logic ramLayer;
	logic [`TM_INDEX_W-1:0] ramIndex;
	logic [`TM_PATTERN_W-1:0] ramPattern;
	logic [`TM_COLOUR_W-1:0] ramAttr;
	logic cpuWe;
	logic [`TM_ADDR_W-1:0] cpuAddr;
	mdiWord_u cpuData;
	logic cpuReady;
	logic flip;
	logic [`TM_PRIO_W-1:0] priIn;
	logic [`TM_COLOUR_W-1:0] colourIn;
	logic [`TM_DOT_W-1:0] dotIn;
	logic pixelValid;
	logic [IDX_W-1:0] palIndex;
	logic [`TM_PRIO_W-1:0] pixelPri;
	logic transparent;

	// Reference model state
	logic [`TM_PATTERN_W-1:0] patA [`TM_GROUPS];
	logic [`TM_PATTERN_W-1:0] patB [`TM_GROUPS];
	logic [`TM_COLOUR_W-1:0] attrA [`TM_GROUPS];
	logic [`TM_COLOUR_W-1:0] attrB [`TM_GROUPS];
	logic [`TM_PRIO_W-1:0] modelPrioA;
	logic [`TM_PRIO_W-1:0] modelPrioB;
	logic [IDX_W-1:0] expIdx [NPIX];
	logic [`TM_PRIO_W-1:0] expPri [NPIX];
	logic expTr [NPIX];

	logic [15:0] lfsr;
	int errors;
	int cycles;
	int testsPassed;
	int testsFailed;

	tilemapTop u_tilemapTop (
		.CLK_6M(CLK_6M), .rstN(rstN),
		.ramWe(ramWe), .ramLayer(ramLayer), .ramIndex(ramIndex),
		.ramPattern(ramPattern), .ramAttr(ramAttr),
		.cpuWe(cpuWe), .cpuAddr(cpuAddr), .cpuData(cpuData), .cpuReady(cpuReady),
		.flip(flip), .priIn(priIn), .colourIn(colourIn), .dotIn(dotIn),
		.pixelValid(pixelValid), .palIndex(palIndex),
		.pixelPri(pixelPri), .transparent(transparent)
	);

	initial CLK_6M = 1'b0;
	always #5 CLK_6M = ~CLK_6M;

	// Run limit
	always @(posedge CLK_6M) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the DUT stopped producing lines", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	////////////////////
	// Random data
	////////////////////

	// Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[14:0], fb};
		end
		return r;
	endfunction

	////////////////////
	// Compare tasks
	////////////////////

	task automatic checkPixel(input logic [IDX_W-1:0] got, input logic [IDX_W-1:0] exp,
			input string msg);
		if (got !== exp) begin
			$display("mismatch at %0t: %s palIndex got %h expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	task automatic checkPri(input logic [`TM_PRIO_W-1:0] got,
			input logic [`TM_PRIO_W-1:0] exp, input string msg);
		if (got !== exp) begin
			$display("mismatch at %0t: %s pixelPri got %0d expected %0d", $time, msg, got, exp);
			errors++;
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string msg);
		if (got !== exp) begin
			$display("mismatch at %0t: %s transparent got %b expected %b", $time, msg, got, exp);
			errors++;
		end
	endtask

	////////////////////
	// Stimulus
	////////////////////

	// Fill both row memories with layer B patterns optionally blank
	task automatic fillRows(input logic blankB);
		for (int l = 0; l < 2; l++) begin
			for (int g = 0; g < `TM_GROUPS; g++) begin
				@(negedge CLK_6M);
				ramWe = 1'b1;
				ramLayer = l[0];
				ramIndex = g[`TM_INDEX_W-1:0];
				ramPattern = `TM_PATTERN_W'(randBits(`TM_PATTERN_W));
				ramAttr = `TM_COLOUR_W'(randBits(`TM_COLOUR_W));
				if (l == 1 && blankB) begin
					ramPattern = '0;
				end
				if (l == 0) begin
					patA[g] = ramPattern;
					attrA[g] = ramAttr;
				end else begin
					patB[g] = ramPattern;
					attrB[g] = ramAttr;
				end
			end
		end
		@(negedge CLK_6M);
		ramWe = 1'b0;
	endtask

	// Priority write held until ready is seen
	task automatic cpuWrite(input logic [`TM_ADDR_W-1:0] addr,
			input logic [`TM_PRIO_W-1:0] prio, output int waits);
		waits = 0;
		cpuWe = 1'b1;
		cpuAddr = addr;
		cpuData = '0;
		cpuData.regs.prio = prio;
		#1;
		while (!cpuReady) begin
			waits++;
			@(negedge CLK_6M);
			#1;
		end
		// Rising edge in between completes the write
		@(negedge CLK_6M);
		cpuWe = 1'b0;
		if (addr == `TM_REG_PRIO_A) modelPrioA = prio;
		if (addr == `TM_REG_PRIO_B) modelPrioB = prio;
	endtask

	task automatic setPrios(input logic [`TM_PRIO_W-1:0] pa, input logic [`TM_PRIO_W-1:0] pb);
		int waits;
		@(negedge CLK_6M);
		cpuWrite(`TM_REG_PRIO_A, pa, waits);
		cpuWrite(`TM_REG_PRIO_B, pb, waits);
	endtask

	////////////////////
	// Reference model
	////////////////////

	task automatic buildExpected;
		int b;
		logic [`TM_DOT_W-1:0] da;
		logic [`TM_DOT_W-1:0] db;
		logic [`TM_DOT_W-1:0] md;
		logic [`TM_PRIO_W-1:0] mp;
		logic [`TM_COLOUR_W-1:0] mc;
		for (int g = 0; g < `TM_GROUPS; g++) begin
			for (int k = 0; k < `TM_PLANE_W; k++) begin
				// Bit 3 leaves first and bit 0 under flip
				b = flip ? k : `TM_PLANE_W - 1 - k;
				for (int i = 0; i < `TM_DOT_W; i++) begin
					da[i] = patA[g][i*`TM_PLANE_W + b];
					db[i] = patB[g][i*`TM_PLANE_W + b];
				end
				if (db != 0 && modelPrioB > modelPrioA) begin
					mp = modelPrioB;
					mc = attrB[g];
					md = db;
				end else begin
					mp = modelPrioA;
					mc = attrA[g];
					md = da;
				end
				// Upstream layer keeps ties and zero dots
				if (!(md != 0 && mp > priIn)) begin
					mp = priIn;
					mc = colourIn;
					md = dotIn;
				end
				expIdx[g*`TM_PLANE_W + k] = {mc, md};
				expPri[g*`TM_PLANE_W + k] = mp;
				expTr[g*`TM_PLANE_W + k] = (md == 0);
			end
		end
	endtask

	////////////////////
	// Line capture
	////////////////////

	// Ends on the first valid pixel of a full line
	task automatic syncLine;
		while (pixelValid) @(negedge CLK_6M);
		while (!pixelValid) @(negedge CLK_6M);
	endtask

	// Capture one run of valid pixels and the blank gap after it
	task automatic captureLine(input logic compare, input string msg);
		int n;
		int gap;
		n = 0;
		gap = 0;
		while (pixelValid) begin
			if (compare && n < NPIX) begin
				checkPixel(palIndex, expIdx[n], $sformatf("%s pixel %0d", msg, n));
				checkPri(pixelPri, expPri[n], $sformatf("%s pixel %0d", msg, n));
				checkFlag(transparent, expTr[n], $sformatf("%s pixel %0d", msg, n));
			end
			n++;
			@(negedge CLK_6M);
		end
		while (!pixelValid && gap < 2 * `TM_LINE_LEN) begin
			// Blanking holds index and priority at zero
			if (compare) begin
				checkPixel(palIndex, '0, $sformatf("%s blank %0d", msg, gap));
				checkPri(pixelPri, '0, $sformatf("%s blank %0d", msg, gap));
			end
			gap++;
			@(negedge CLK_6M);
		end
		if (n != NPIX) begin
			$display("%s: line gave %0d valid pixels instead of %0d", msg, n, NPIX);
			errors++;
		end
		if (gap != `TM_LINE_LEN - NPIX) begin
			$display("%s: blanking lasted %0d cycles instead of %0d", msg, gap,
				`TM_LINE_LEN - NPIX);
			errors++;
		end
	endtask

	// First line may hold stale loads, so it is only counted
	task automatic verifyLine(input string msg);
		buildExpected();
		syncLine();
		captureLine(1'b0, msg);
		captureLine(1'b1, msg);
	endtask

	task automatic reportTest(input string name, input int errBefore);
		if (errors == errBefore) begin
			$display("test %s: ok", name);
			testsPassed++;
		end else begin
			$display("test %s: failed with %0d errors", name, errors - errBefore);
			testsFailed++;
		end
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic layerAOnly;
		int e;
		e = errors;
		flip = 1'b0;
		priIn = 3'd0;
		colourIn = `TM_COLOUR_W'(randBits(`TM_COLOUR_W));
		dotIn = 3'd2;
		fillRows(1'b1);
		setPrios(3'd1, 3'd0);
		verifyLine("layerA");
		reportTest("layer A only", e);
	endtask

	task automatic layerBOverride;
		int e;
		e = errors;
		priIn = 3'd0;
		dotIn = 3'd0;
		fillRows(1'b0);
		setPrios(3'd2, 3'd5);
		verifyLine("B above A");
		// Equal priorities keep A
		setPrios(3'd4, 3'd4);
		verifyLine("B equal A");
		reportTest("layer B override", e);
	endtask

	task automatic inputLayerWins;
		int e;
		e = errors;
		setPrios(3'd3, 3'd5);
		@(negedge CLK_6M);
		priIn = 3'd7;
		dotIn = 3'd5;
		colourIn = `TM_COLOUR_W'(randBits(`TM_COLOUR_W));
		verifyLine("input dot 5");
		@(negedge CLK_6M);
		priIn = 3'd5;
		dotIn = 3'd0;
		verifyLine("input dot 0");
		reportTest("input layer wins", e);
	endtask

	task automatic flipOrder;
		int e;
		e = errors;
		@(negedge CLK_6M);
		priIn = 3'd1;
		dotIn = 3'd3;
		flip = 1'b1;
		fillRows(1'b0);
		setPrios(3'd2, 3'd4);
		verifyLine("flip");
		reportTest("horizontal flip", e);
	endtask

	task automatic busyWrite;
		int e;
		int waits;
		e = errors;
		flip = 1'b0;
		priIn = 3'd0;
		setPrios(3'd4, 3'd1);
		// Valid pixel 0 sits in phase 1 so the next cycle is phase 2
		syncLine();
		@(negedge CLK_6M);
		cpuWrite(`TM_REG_PRIO_B, 3'd6, waits);
		if (waits == 0) begin
			$display("write in phase 2 was accepted without waiting for cpuReady");
			errors++;
		end
		buildExpected();
		// Finish the disturbed line, then check the next ones
		while (pixelValid) @(negedge CLK_6M);
		syncLine();
		captureLine(1'b1, "after write");
		captureLine(1'b1, "second line");
		reportTest("busy write", e);
	endtask

	initial begin
		lfsr = 16'd37790;
		errors = 0;
		cycles = 0;
		testsPassed = 0;
		testsFailed = 0;
		modelPrioA = '0;
		modelPrioB = '0;
		rstN = 1'b0;
		ramWe = 1'b0;
		ramLayer = 1'b0;
		ramIndex = '0;
		ramPattern = '0;
		ramAttr = '0;
		cpuWe = 1'b0;
		cpuAddr = '0;
		cpuData = '0;
		flip = 1'b0;
		priIn = '0;
		colourIn = '0;
		dotIn = '0;
		repeat (4) @(posedge CLK_6M);
		@(negedge CLK_6M);
		rstN = 1'b1;

		layerAOnly();
		layerBOverride();
		inputLayerWins();
		flipOrder();
		busyWrite();

		$display("tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+src
src/tilemapPkg.sv
src/tileFetcher.sv
src/tileShifter.sv
src/pixelOutput.sv
src/tilemapTop.sv
dv/tilemap_properties.sv
dv/tilemapTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = tilemapTb
FILELIST = compile.f
OBJDIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
